/* Makefile */
TOP := tb_soc_domain

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir

/* source/addr_decoder.sv */
// Decodes the shared bus onto the SRAM, GPIO and pulser peers and merges their responses
// Unmapped addresses are answered here with the error word and err set
`timescale 1ns/1ps
`default_nettype none

module addr_decoder import soc_bus_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  arst_n_i,
  obi_bus_if.sbr     shared_bus,
  output logic       sram_req_o,
  output logic       gpio_req_o,
  output logic       pulser_req_o,
  output addr_t      offset_o,
  output logic       we_o,
  output be_t        be_o,
  output data_t      wdata_o,
  input  wire data_t sram_rdata_i,
  input  wire data_t gpio_rdata_i,
  input  wire data_t pulser_rdata_i
);

  addr_t sram_off;
  addr_t gpio_off;
  addr_t pulser_off;
  logic  hit_sram, hit_gpio, hit_pulser;
  logic  access;
  logic  rvalid_q, we_q;
  logic  sram_q, gpio_q, miss_q;

  // --------------------
  // Window compare
  // --------------------
  // Unsigned wrap makes addresses below the base miss too
  assign sram_off   = shared_bus.addr - SramBase;
  assign gpio_off   = shared_bus.addr - GpioBase;
  assign pulser_off = shared_bus.addr - PulserBase;
  assign hit_sram   = sram_off < SramSize;
  assign hit_gpio   = gpio_off < GpioSize;
  assign hit_pulser = pulser_off < PulserSize;

  // Every peer answers in one cycle
  assign shared_bus.gnt = shared_bus.req;
  assign access         = shared_bus.req && shared_bus.gnt;

  assign sram_req_o   = access && hit_sram;
  assign gpio_req_o   = access && hit_gpio;
  assign pulser_req_o = access && hit_pulser;

  always_comb begin
    if (hit_sram) begin
      offset_o = sram_off;
    end else if (hit_gpio) begin
      offset_o = gpio_off;
    end else begin
      offset_o = pulser_off;
    end
  end

  assign we_o    = shared_bus.we;
  assign be_o    = shared_bus.be;
  assign wdata_o = shared_bus.wdata;

  // --------------------
  // Response cycle
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      we_q     <= 1'b0;
      sram_q   <= 1'b0;
      gpio_q   <= 1'b0;
      miss_q   <= 1'b0;
    end else begin
      rvalid_q <= access;
      if (access) begin
        we_q   <= shared_bus.we;
        sram_q <= hit_sram;
        gpio_q <= hit_gpio;
        miss_q <= !(hit_sram || hit_gpio || hit_pulser);
      end
    end
  end

  always_comb begin
    if (miss_q) begin
      shared_bus.rdata = ErrWord;
    end else if (we_q) begin
      shared_bus.rdata = '0;
    end else if (sram_q) begin
      shared_bus.rdata = sram_rdata_i;
    end else if (gpio_q) begin
      shared_bus.rdata = gpio_rdata_i;
    end else begin
      shared_bus.rdata = pulser_rdata_i;
    end
  end

  assign shared_bus.rvalid = rvalid_q;
  assign shared_bus.err    = rvalid_q && miss_q;

  // Each granted request gets exactly one response, on the next cycle
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    shared_bus.rvalid == $past(shared_bus.req && shared_bus.gnt));

endmodule

`default_nettype wire

/* source/bus_arbiter.sv */
// Round-robin arbiter merging the host and debug managers onto the shared bus
// Only one transaction is in flight at a time
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import soc_bus_pkg::*; (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  obi_bus_if.sbr    host_bus,
  obi_bus_if.sbr    dbg_bus,
  obi_bus_if.mgr    shared_bus
);

  logic pending_q;
  logic last_dbg_q;
  logic sel_dbg;
  logic grant;

  // --------------------
  // Request side
  // --------------------
  // Debug wins when alone, or on a tie when the host was served last
  assign sel_dbg = dbg_bus.req && (!host_bus.req || !last_dbg_q);

  assign shared_bus.req   = !pending_q && (host_bus.req || dbg_bus.req);
  assign shared_bus.addr  = sel_dbg ? dbg_bus.addr  : host_bus.addr;
  assign shared_bus.we    = sel_dbg ? dbg_bus.we    : host_bus.we;
  assign shared_bus.be    = sel_dbg ? dbg_bus.be    : host_bus.be;
  assign shared_bus.wdata = sel_dbg ? dbg_bus.wdata : host_bus.wdata;

  assign grant        = shared_bus.req && shared_bus.gnt;
  assign host_bus.gnt = grant && !sel_dbg;
  assign dbg_bus.gnt  = grant && sel_dbg;

  // Last served manager is also the owner of the pending response
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q  <= 1'b0;
      last_dbg_q <= 1'b0;
    end else if (grant) begin
      pending_q  <= 1'b1;
      last_dbg_q <= sel_dbg;
    end else if (shared_bus.rvalid) begin
      pending_q <= 1'b0;
    end
  end

  // --------------------
  // Response side
  // --------------------
  assign host_bus.rvalid = shared_bus.rvalid && !last_dbg_q;
  assign dbg_bus.rvalid  = shared_bus.rvalid && last_dbg_q;
  assign host_bus.rdata  = shared_bus.rdata;
  assign dbg_bus.rdata   = shared_bus.rdata;
  assign host_bus.err    = shared_bus.err && !last_dbg_q;
  assign dbg_bus.err     = shared_bus.err && last_dbg_q;

  // No manager is granted while a response is still outstanding
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (host_bus.gnt || dbg_bus.gnt) |=> !(host_bus.gnt || dbg_bus.gnt));

endmodule

`default_nettype wire

/* source/gpio_block.sv */
// GPIO registers with a two-flop input synchronizer and rising-edge interrupt
// Status bits are cleared by writing 1
`timescale 1ns/1ps
`default_nettype none

module gpio_block import soc_bus_pkg::*; #(
  parameter int unsigned GpioCount = 16
) (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic                 req_i,
  input  wire addr_t                offset_i,
  input  wire logic                 we_i,
  input  wire data_t                wdata_i,
  output data_t                     rdata_o,
  input  wire logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0]      gpio_o,
  output logic [GpioCount-1:0]      gpio_out_en_o,
  output logic [GpioCount-1:0]      gpio_in_sync_o,
  output logic                      irq_o
);

  typedef logic [GpioCount-1:0] pins_t;

  pins_t dir_q, out_q, irq_en_q, irq_stat_q;
  pins_t sync1_q, sync2_q, prev_q;
  pins_t wr_bits;
  pins_t stat_clr;
  pins_t rise;
  logic  wr;

  assign wr       = req_i && we_i;
  assign wr_bits  = wdata_i[GpioCount-1:0];
  assign stat_clr = (wr && offset_i == GpioIrqStatOff) ? wr_bits : '0;
  assign rise     = sync2_q & ~prev_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q      <= '0;
      out_q      <= '0;
      irq_en_q   <= '0;
      irq_stat_q <= '0;
      sync1_q    <= '0;
      sync2_q    <= '0;
      prev_q     <= '0;
    end else begin
      sync1_q    <= gpio_i;
      sync2_q    <= sync1_q;
      prev_q     <= sync2_q;
      // New edges win over a clear in the same cycle
      irq_stat_q <= (irq_stat_q & ~stat_clr) | (rise & irq_en_q);
      if (wr && offset_i == GpioDirOff) begin
        dir_q <= wr_bits;
      end
      if (wr && offset_i == GpioOutOff) begin
        out_q <= wr_bits;
      end
      if (wr && offset_i == GpioIrqEnOff) begin
        irq_en_q <= wr_bits;
      end
    end
  end

  // --------------------
  // Register read
  // --------------------
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (offset_i)
        GpioDirOff:     rdata_o <= data_t'(dir_q);
        GpioOutOff:     rdata_o <= data_t'(out_q);
        GpioInOff:      rdata_o <= data_t'(sync2_q);
        GpioIrqEnOff:   rdata_o <= data_t'(irq_en_q);
        GpioIrqStatOff: rdata_o <= data_t'(irq_stat_q);
        default:        rdata_o <= '0;
      endcase
    end
  end

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |irq_stat_q;

endmodule

`default_nettype wire

/* source/obi_bus_if.sv */
// One manager-to-subordinate bus with the req/gnt/rvalid handshake
// Managers connect through mgr, subordinates through sbr
`timescale 1ns/1ps
`default_nettype none

interface obi_bus_if import soc_bus_pkg::*; ();

  // Request channel
  logic  req;
  logic  gnt;
  addr_t addr;
  logic  we;
  be_t   be;
  data_t wdata;

  // Response channel, one cycle after the grant
  logic  rvalid;
  data_t rdata;
  logic  err;

  modport mgr (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport sbr (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

`default_nettype wire

/* source/pulser_bank.sv */
// Bank of periodic pulse generators, one period register per channel at offset 4k
// Period P gives a one-cycle pulse every P+1 cycles and period 0 stops the channel
`timescale 1ns/1ps
`default_nettype none

module pulser_bank import soc_bus_pkg::*; #(
  parameter int unsigned NumPulsers = 4
) (
  input  wire logic        clk_i,
  input  wire logic        arst_n_i,
  input  wire logic        req_i,
  input  wire addr_t       offset_i,
  input  wire logic        we_i,
  input  wire data_t       wdata_i,
  output data_t            rdata_o,
  output logic [NumPulsers-1:0] pulse_o
);

  data_t period_q [NumPulsers];
  data_t count_q  [NumPulsers];
  logic [NumPulsers-1:0] sel;
  logic wr;

  assign wr = req_i && we_i;

  for (genvar k = 0; k < NumPulsers; k++) begin : gen_chan
    assign sel[k] = (offset_i == addr_t'(4 * k));

    // Counter runs 0..P and restarts on every period write
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        period_q[k] <= '0;
        count_q[k]  <= '0;
      end else if (wr && sel[k]) begin
        period_q[k] <= wdata_i;
        count_q[k]  <= '0;
      end else if (count_q[k] >= period_q[k]) begin
        count_q[k] <= '0;
      end else begin
        count_q[k] <= count_q[k] + 1'b1;
      end
    end

    assign pulse_o[k] = (period_q[k] != '0) && (count_q[k] == period_q[k]);

    // A stopped channel keeps its counter parked at zero
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (period_q[k] == '0) |-> (count_q[k] == '0));
  end

  // --------------------
  // Register read
  // --------------------
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= '0;
      for (int i = 0; i < NumPulsers; i++) begin
        if (sel[i]) begin
          rdata_o <= period_q[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/soc_bus_pkg.sv */
// Bus types, address map and register offsets shared by the SoC domain blocks
// Imported by wildcard into every module that carries bus data or decodes addresses
`default_nettype none

package soc_bus_pkg;

  // --------------------
  // Bus widths
  // --------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [7:0]  word_idx_t;

  // --------------------
  // Address map
  // --------------------
  localparam addr_t SramBase   = 32'h1000_0000;
  localparam addr_t SramSize   = 32'h0000_0400;
  localparam addr_t GpioBase   = 32'h0300_0000;
  localparam addr_t GpioSize   = 32'h0000_1000;
  localparam addr_t PulserBase = 32'h0300_1000;
  localparam addr_t PulserSize = 32'h0000_1000;

  // Read data for unmapped accesses
  localparam data_t ErrWord = 32'hBADC_AB1E;

  // GPIO register offsets
  localparam addr_t GpioDirOff     = 32'h00;
  localparam addr_t GpioOutOff     = 32'h04;
  localparam addr_t GpioInOff      = 32'h08;
  localparam addr_t GpioIrqEnOff   = 32'h0C;
  localparam addr_t GpioIrqStatOff = 32'h10;

endpackage

`default_nettype wire

/* source/soc_domain.sv */
// RTL top level of the SoC domain with host and debug manager ports
// Maps the plain ports onto bus interfaces and connects the arbiter, decoder and peers
`timescale 1ns/1ps
`default_nettype none

module soc_domain import soc_bus_pkg::*; #(
  parameter int unsigned GpioCount  = 16,
  parameter int unsigned NumPulsers = 4,
  parameter int unsigned SramWords  = 256
) (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  // Host manager port
  input  wire logic                 host_req_i,
  output logic                      host_gnt_o,
  input  wire addr_t                host_addr_i,
  input  wire logic                 host_we_i,
  input  wire be_t                  host_be_i,
  input  wire data_t                host_wdata_i,
  output logic                      host_rvalid_o,
  output data_t                     host_rdata_o,
  output logic                      host_err_o,
  // Debug manager port
  input  wire logic                 dbg_req_i,
  output logic                      dbg_gnt_o,
  input  wire addr_t                dbg_addr_i,
  input  wire logic                 dbg_we_i,
  input  wire be_t                  dbg_be_i,
  input  wire data_t                dbg_wdata_i,
  output logic                      dbg_rvalid_o,
  output data_t                     dbg_rdata_o,
  output logic                      dbg_err_o,
  // Pins
  input  wire logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0]      gpio_o,
  output logic [GpioCount-1:0]      gpio_out_en_o,
  output logic [GpioCount-1:0]      gpio_in_sync_o,
  output logic                      gpio_irq_o,
  output logic [NumPulsers-1:0]     pulse_o
);

  obi_bus_if host_bus ();
  obi_bus_if dbg_bus ();
  obi_bus_if shared_bus ();

  logic  sram_req, gpio_req, pulser_req;
  addr_t peer_offset;
  logic  peer_we;
  be_t   peer_be;
  data_t peer_wdata;
  data_t sram_rdata, gpio_rdata, pulser_rdata;

  // --------------------
  // Manager ports
  // --------------------
  assign host_bus.req   = host_req_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.be    = host_be_i;
  assign host_bus.wdata = host_wdata_i;
  assign host_gnt_o     = host_bus.gnt;
  assign host_rvalid_o  = host_bus.rvalid;
  assign host_rdata_o   = host_bus.rdata;
  assign host_err_o     = host_bus.err;

  assign dbg_bus.req    = dbg_req_i;
  assign dbg_bus.addr   = dbg_addr_i;
  assign dbg_bus.we     = dbg_we_i;
  assign dbg_bus.be     = dbg_be_i;
  assign dbg_bus.wdata  = dbg_wdata_i;
  assign dbg_gnt_o      = dbg_bus.gnt;
  assign dbg_rvalid_o   = dbg_bus.rvalid;
  assign dbg_rdata_o    = dbg_bus.rdata;
  assign dbg_err_o      = dbg_bus.err;

  // --------------------
  // Interconnect
  // --------------------
  bus_arbiter i_bus_arbiter (
    .clk_i,
    .arst_n_i,
    .host_bus,
    .dbg_bus,
    .shared_bus
  );

  addr_decoder i_addr_decoder (
    .clk_i,
    .arst_n_i,
    .shared_bus,
    .sram_req_o     ( sram_req     ),
    .gpio_req_o     ( gpio_req     ),
    .pulser_req_o   ( pulser_req   ),
    .offset_o       ( peer_offset  ),
    .we_o           ( peer_we      ),
    .be_o           ( peer_be      ),
    .wdata_o        ( peer_wdata   ),
    .sram_rdata_i   ( sram_rdata   ),
    .gpio_rdata_i   ( gpio_rdata   ),
    .pulser_rdata_i ( pulser_rdata )
  );

  // --------------------
  // Peers
  // --------------------
  sram_bank #(
    .SramWords ( SramWords )
  ) i_sram_bank (
    .clk_i,
    .req_i    ( sram_req    ),
    .offset_i ( peer_offset ),
    .we_i     ( peer_we     ),
    .be_i     ( peer_be     ),
    .wdata_i  ( peer_wdata  ),
    .rdata_o  ( sram_rdata  )
  );

  gpio_block #(
    .GpioCount ( GpioCount )
  ) i_gpio_block (
    .clk_i,
    .arst_n_i,
    .req_i          ( gpio_req    ),
    .offset_i       ( peer_offset ),
    .we_i           ( peer_we     ),
    .wdata_i        ( peer_wdata  ),
    .rdata_o        ( gpio_rdata  ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .irq_o          ( gpio_irq_o  )
  );

  pulser_bank #(
    .NumPulsers ( NumPulsers )
  ) i_pulser_bank (
    .clk_i,
    .arst_n_i,
    .req_i    ( pulser_req   ),
    .offset_i ( peer_offset  ),
    .we_i     ( peer_we      ),
    .wdata_i  ( peer_wdata   ),
    .rdata_o  ( pulser_rdata ),
    .pulse_o
  );

endmodule

`default_nettype wire

/* source/sram_bank.sv */
// Single-port word memory with byte-enable writes and one cycle of read latency
`timescale 1ns/1ps
`default_nettype none

module sram_bank import soc_bus_pkg::*; #(
  parameter int unsigned SramWords = 256
) (
  input  wire logic  clk_i,
  input  wire logic  req_i,
  input  wire addr_t offset_i,
  input  wire logic  we_i,
  input  wire be_t   be_i,
  input  wire data_t wdata_i,
  output data_t      rdata_o
);

  data_t     mem_q [SramWords];
  word_idx_t idx;

  // Byte offset to word index
  assign idx = offset_i[$bits(word_idx_t)+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

  // Decoder window must fit inside the memory depth
  assert property (@(posedge clk_i) req_i |-> (int'(idx) < SramWords));

endmodule

`default_nettype wire

/* tests/soc_stim.txt */
// Columns in hex: test cmd mgr addr wdata be exp_rdata exp_err
// cmd 1 write, 2 read, 3 dual (mgr is the expected winner), 4 pin (addr selects the pin), 5 wait
// Pin 0 drives gpio_i, 1 gpio_o, 2 gpio_out_en_o, 3 gpio_in_sync_o, 4 irq, 5 period of ch wdata, 6 pulse_o
1 1 0 10000000 DEADBEEF F 00000000 0
1 2 0 10000000 00000000 F DEADBEEF 0
1 1 1 10000004 12345678 F 00000000 0
1 2 1 10000004 00000000 F 12345678 0
1 2 0 10000004 00000000 F 12345678 0
1 1 0 10000000 11223344 5 00000000 0
1 2 1 10000000 00000000 F DE22BE44 0
1 1 1 10000004 AA000000 8 00000000 0
1 2 0 10000004 00000000 F AA345678 0
2 2 0 20000000 00000000 F BADCAB1E 1
2 1 0 04000000 55555555 F BADCAB1E 1
2 2 1 10000400 00000000 F BADCAB1E 1
3 3 0 10000010 CAFE0001 F 00000000 0
3 2 1 10000010 00000000 F CAFE0001 0
3 2 0 10000014 00000000 F 3501FFFE 0
3 3 1 10000020 0F0F0F0F F 00000000 0
3 2 0 10000020 00000000 F 0F0F0F0F 0
3 2 1 10000024 00000000 F F0F0F0F0 0
4 4 0 00000001 00000000 0 00000000 0
4 4 0 00000002 00000000 0 00000000 0
4 1 0 03000000 000000FF F 00000000 0
4 1 1 03000004 000000A5 F 00000000 0
4 4 0 00000002 00000000 0 000000FF 0
4 4 0 00000001 00000000 0 000000A5 0
4 2 1 03000000 00000000 F 000000FF 0
4 4 0 00000000 00001234 0 00000000 0
4 5 0 00000000 00000003 0 00000000 0
4 4 0 00000003 00000000 0 00001234 0
4 2 0 03000008 00000000 F 00001234 0
5 1 0 0300000C 00000001 F 00000000 0
5 4 0 00000004 00000000 0 00000000 0
5 4 0 00000000 00001235 0 00000000 0
5 5 0 00000000 00000004 0 00000000 0
5 4 0 00000004 00000000 0 00000001 0
5 2 1 03000010 00000000 F 00000001 0
5 1 1 03000010 00000001 F 00000000 0
5 4 0 00000004 00000000 0 00000000 0
5 2 0 03000010 00000000 F 00000000 0
6 4 0 00000006 00000000 0 00000000 0
6 1 0 03001004 00000003 F 00000000 0
6 4 0 00000005 00000001 0 00000004 0
6 1 1 03001008 00000006 F 00000000 0
6 4 0 00000005 00000002 0 00000007 0
6 4 0 00000005 00000000 0 00000000 0
6 1 0 0300100C 00000002 F 00000000 0
6 4 0 00000005 00000003 0 00000003 0
6 1 0 0300100C 00000000 F 00000000 0
6 4 0 00000005 00000003 0 00000000 0
6 2 1 03001004 00000000 F 00000003 0

/* tests/tb_soc_domain.sv */
// Testbench for the SoC domain that replays bus and pin operations from tests/soc_stim.txt
// Every stim line is executed in order and checked against the expected values it carries
`timescale 1ns/1ps
`default_nettype none

module tb_soc_domain import soc_bus_pkg::*; ();

  localparam int ClkPeriod     = 100;
  localparam int ResetCycles   = 8;
  localparam int Cols          = 8;
  localparam int MaxLines      = 64;
  localparam int GrantTimeout  = 16;
  localparam int PulseWindow   = 24;
  localparam int CyclesPerLine = 40;

  // Stim commands
  localparam logic [31:0] CmdWrite = 32'h1;
  localparam logic [31:0] CmdRead  = 32'h2;
  localparam logic [31:0] CmdDual  = 32'h3;
  localparam logic [31:0] CmdPin   = 32'h4;
  localparam logic [31:0] CmdWait  = 32'h5;

  logic        clk;
  logic        arst_n;
  logic        host_req;
  logic        host_gnt;
  logic [31:0] host_addr;
  logic        host_we;
  logic [3:0]  host_be;
  logic [31:0] host_wdata;
  logic        host_rvalid;
  logic [31:0] host_rdata;
  logic        host_err;
  logic        dbg_req;
  logic        dbg_gnt;
  logic [31:0] dbg_addr;
  logic        dbg_we;
  logic [3:0]  dbg_be;
  logic [31:0] dbg_wdata;
  logic        dbg_rvalid;
  logic [31:0] dbg_rdata;
  logic        dbg_err;
  logic [15:0] gpio_in;
  logic [15:0] gpio_out;
  logic [15:0] gpio_en;
  logic [15:0] gpio_sync;
  logic        gpio_irq;
  logic [3:0]  pulse;

  logic [31:0] stim_mem [MaxLines*Cols];
  int          line_count = 0;
  int          cycle = 0;
  int          test_errors = 0;
  int          total_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  soc_domain soc_domain_i (
    .clk_i          ( clk         ),
    .arst_n_i       ( arst_n      ),
    .host_req_i     ( host_req    ),
    .host_gnt_o     ( host_gnt    ),
    .host_addr_i    ( host_addr   ),
    .host_we_i      ( host_we     ),
    .host_be_i      ( host_be     ),
    .host_wdata_i   ( host_wdata  ),
    .host_rvalid_o  ( host_rvalid ),
    .host_rdata_o   ( host_rdata  ),
    .host_err_o     ( host_err    ),
    .dbg_req_i      ( dbg_req     ),
    .dbg_gnt_o      ( dbg_gnt     ),
    .dbg_addr_i     ( dbg_addr    ),
    .dbg_we_i       ( dbg_we      ),
    .dbg_be_i       ( dbg_be      ),
    .dbg_wdata_i    ( dbg_wdata   ),
    .dbg_rvalid_o   ( dbg_rvalid  ),
    .dbg_rdata_o    ( dbg_rdata   ),
    .dbg_err_o      ( dbg_err     ),
    .gpio_i         ( gpio_in     ),
    .gpio_o         ( gpio_out    ),
    .gpio_out_en_o  ( gpio_en     ),
    .gpio_in_sync_o ( gpio_sync   ),
    .gpio_irq_o     ( gpio_irq    ),
    .pulse_o        ( pulse       )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Cycle stamp that is read mid-cycle only
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // --------------------
  // Checks
  // --------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("at %0t ns: %s", $time, what);
      test_errors++;
      total_errors++;
    end
  endtask

  function automatic string region_of(input logic [31:0] addr);
    if (addr >= SramBase && addr < SramBase + SramSize) return "sram";
    if (addr >= GpioBase && addr < GpioBase + GpioSize) return "gpio";
    if (addr >= PulserBase && addr < PulserBase + PulserSize) return "pulser";
    return "unmapped";
  endfunction

  // --------------------
  // Bus driver
  // --------------------
  task automatic drive_request(input int mgr, input logic req, input logic we,
                               input logic [31:0] addr, input logic [3:0] be,
                               input logic [31:0] wdata);
    if (mgr == 0) begin
      host_req   = req;
      host_we    = we;
      host_addr  = addr;
      host_be    = be;
      host_wdata = wdata;
    end else begin
      dbg_req    = req;
      dbg_we     = we;
      dbg_addr   = addr;
      dbg_be     = be;
      dbg_wdata  = wdata;
    end
  endtask

  function automatic logic gnt_of(input int mgr);
    return (mgr == 0) ? host_gnt : dbg_gnt;
  endfunction

  function automatic logic rvalid_of(input int mgr);
    return (mgr == 0) ? host_rvalid : dbg_rvalid;
  endfunction

  // Starts and ends on a falling edge and samples gnt a quarter period later
  task automatic bus_access(input int mgr, input logic we, input logic [31:0] addr,
                            input logic [3:0] be, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err,
                            output int grant_cycle);
    int waited;
    waited = 0;
    rdata = '0;
    err = 1'b0;
    grant_cycle = 0;
    drive_request(mgr, 1'b1, we, addr, be, wdata);
    #(ClkPeriod / 4);
    while (!gnt_of(mgr) && waited < GrantTimeout) begin
      check_true(!(host_gnt && dbg_gnt), "both managers granted in the same cycle");
      @(negedge clk);
      #(ClkPeriod / 4);
      waited++;
    end
    check_true(!(host_gnt && dbg_gnt), "both managers granted in the same cycle");
    if (!gnt_of(mgr)) begin
      check_true(1'b0, "request was never granted");
      @(negedge clk);
      drive_request(mgr, 1'b0, 1'b0, '0, '0, '0);
      return;
    end
    grant_cycle = cycle;
    @(negedge clk);
    drive_request(mgr, 1'b0, 1'b0, '0, '0, '0);
    check_true(rvalid_of(mgr), "response did not come one cycle after the grant");
    waited = 0;
    while (!rvalid_of(mgr) && waited < GrantTimeout) begin
      @(negedge clk);
      waited++;
    end
    check_true(rvalid_of(mgr), "no response arrived for a granted request");
    rdata = (mgr == 0) ? host_rdata : dbg_rdata;
    err   = (mgr == 0) ? host_err : dbg_err;
  endtask

  // Cycles between two pulses of one channel or 0 when none shows up
  task automatic measure_period(input int chan, output int period);
    int waited;
    int start;
    period = 0;
    waited = 0;
    while (!pulse[chan] && waited < PulseWindow) begin
      @(negedge clk);
      waited++;
    end
    if (!pulse[chan]) return;
    start = cycle;
    @(negedge clk);
    waited = 0;
    while (!pulse[chan] && waited < PulseWindow) begin
      @(negedge clk);
      waited++;
    end
    if (pulse[chan]) period = cycle - start;
  endtask

  // --------------------
  // Stim line execution
  // --------------------
  task automatic run_line(input int line);
    logic [31:0] cmd;
    logic [31:0] mgr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] be;
    logic [31:0] exp_rdata;
    logic [31:0] exp_err;
    logic [31:0] rdata;
    logic [31:0] rdata2;
    logic        err;
    logic        err2;
    int          cyc;
    int          cyc2;
    int          period;
    string       port;
    cmd       = stim_mem[line*Cols+1];
    mgr       = stim_mem[line*Cols+2];
    addr      = stim_mem[line*Cols+3];
    wdata     = stim_mem[line*Cols+4];
    be        = stim_mem[line*Cols+5];
    exp_rdata = stim_mem[line*Cols+6];
    exp_err   = stim_mem[line*Cols+7];
    if (mgr == 0) begin
      port = "host";
    end else begin
      port = "dbg";
    end
    case (cmd)
      CmdWrite, CmdRead: begin
        bus_access(int'(mgr), cmd == CmdWrite, addr, be[3:0], wdata, rdata, err, cyc);
        check_value({port, "_rdata_o at ", region_of(addr)}, exp_rdata, rdata);
        check_value({port, "_err_o"}, exp_err, 32'(err));
      end
      CmdDual: begin
        // Debug writes the inverted word one address up
        fork
          bus_access(0, 1'b1, addr, 4'hF, wdata, rdata, err, cyc);
          bus_access(1, 1'b1, addr + 32'd4, 4'hF, ~wdata, rdata2, err2, cyc2);
        join
        check_true((mgr == 0) ? (cyc < cyc2) : (cyc2 < cyc),
                   "expected manager was not granted first");
        check_value("host_rdata_o", exp_rdata, rdata);
        check_value("dbg_rdata_o", exp_rdata, rdata2);
        check_value("host_err_o", exp_err, 32'(err));
        check_value("dbg_err_o", exp_err, 32'(err2));
      end
      CmdPin: begin
        case (addr)
          32'd0: gpio_in = wdata[15:0];
          32'd1: check_value("gpio_o", exp_rdata, 32'(gpio_out));
          32'd2: check_value("gpio_out_en_o", exp_rdata, 32'(gpio_en));
          32'd3: check_value("gpio_in_sync_o", exp_rdata, 32'(gpio_sync));
          32'd4: check_value("gpio_irq_o", exp_rdata, 32'(gpio_irq));
          32'd5: begin
            measure_period(int'(wdata), period);
            check_value($sformatf("pulse_o[%0d] period", wdata), exp_rdata, 32'(period));
          end
          32'd6: check_value("pulse_o", exp_rdata, 32'(pulse));
          default: check_true(1'b0, "unknown pin selector in the stimulus");
        endcase
      end
      CmdWait: begin
        repeat (wdata) @(negedge clk);
      end
      default: check_true(1'b0, "unknown command in the stimulus");
    endcase
  endtask

  task automatic finish_test(input int id);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d passed", id);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d errors", id, test_errors);
    end
    test_errors = 0;
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main
    int count;
    int cur_test;
    gpio_in = '0;
    arst_n  = 1'b0;
    drive_request(0, 1'b0, 1'b0, '0, '0, '0);
    drive_request(1, 1'b0, 1'b0, '0, '0, '0);
    for (int i = 0; i < MaxLines * Cols; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("tests/soc_stim.txt", stim_mem);
    count = 0;
    while (count < MaxLines && stim_mem[count*Cols+1] != '0) begin
      count++;
    end
    line_count = count;

    repeat (ResetCycles) @(negedge clk);
    arst_n = 1'b1;
    check_true(count > 0, "stimulus file holds no operations");
    check_value("host_gnt_o", '0, 32'(host_gnt));
    check_value("dbg_gnt_o", '0, 32'(dbg_gnt));
    check_value("host_rvalid_o", '0, 32'(host_rvalid));
    check_value("dbg_rvalid_o", '0, 32'(dbg_rvalid));

    cur_test = int'(stim_mem[0]);
    for (int line = 0; line < count; line++) begin
      if (int'(stim_mem[line*Cols]) != cur_test) begin
        finish_test(cur_test);
        cur_test = int'(stim_mem[line*Cols]);
      end
      run_line(line);
    end
    finish_test(cur_test);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Budget scales with the number of stim lines
  initial begin : watchdog
    wait (line_count > 0);
    repeat (line_count * CyclesPerLine) @(posedge clk);
    $display("Watchdog expired after %0d cycles and the run did not complete", cycle);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
source/soc_bus_pkg.sv
source/obi_bus_if.sv
source/bus_arbiter.sv
source/addr_decoder.sv
source/sram_bank.sv
source/gpio_block.sv
source/pulser_bank.sv
source/soc_domain.sv
tests/tb_soc_domain.sv
